// ==== logic/sd_proto_pkg.sv ====
// SD bus protocol definitions
// frame types and constants for the command, response and data paths

package sd_proto_pkg;

	typedef logic [5:0] cmd_index_t;   // command index field
	typedef logic [31:0] cmd_arg_t;    // command argument field
	typedef logic [6:0] crc7_t;        // command frame crc
	typedef logic [47:0] resp_frame_t; // start bit down to end bit

	// bits in a command or short response frame
	localparam int cmd_frame_bits = 48;

	// single block read
	localparam cmd_index_t cmd_read_single = 6'd17;

	// bytes per data block
	localparam int block_bytes = 512;

	// crc bits sent on each data line after a block
	localparam int data_crc_bits = 16;

	// sd_clk periods before a missing response is reported
	localparam int resp_timeout_ticks = 80;

	// block number to byte address on standard capacity cards
	localparam int std_addr_shift = 9;

endpackage

// ==== logic/sd_host_pkg.sv ====
// SD host side definitions
// clock division, timeouts and transfer types of the read host

package sd_host_pkg;

	typedef logic [31:0] block_addr_t; // block number on the card
	typedef logic [7:0] byte_t;        // one data byte
	typedef logic [8:0] byte_index_t;  // byte position inside a block

	// sys_clk cycles per sd_clk half period
	localparam int sd_clk_half = 2;

	// sd_clk periods allowed before the data start nibble
	localparam int data_timeout_ticks = 1024;

endpackage

// ==== logic/sd_clk_div.sv ====
// SD clock divider
// derives sd_clk from sys_clk, with one-cycle strobes on each sd_clk edge

module sd_clk_div (
	input  logic sys_clk,
	input  logic rst,
	output logic sd_clk,
	output logic sd_rise,
	output logic sd_fall
);

	logic [$clog2(sd_host_pkg::sd_clk_half + 1)-1:0] div_cnt;

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			div_cnt <= '0;
			sd_clk <= 1'b0;
			sd_rise <= 1'b0;
			sd_fall <= 1'b0;
		end
		else
		begin
			sd_rise <= 1'b0;
			sd_fall <= 1'b0;
			if (div_cnt == $bits(div_cnt)'(sd_host_pkg::sd_clk_half - 1))
			begin
				div_cnt <= '0;
				sd_clk <= ~sd_clk;
				sd_rise <= ~sd_clk; // strobe follows the new level
				sd_fall <= sd_clk;
			end
			else
			begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	a_strobe_excl: assert property (@(posedge sys_clk) disable iff (rst)
		!(sd_rise && sd_fall));

endmodule

// ==== logic/sd_cmd_tx.sv ====
// SD command transmitter
// sends start, transmission bit, index and argument, then the CRC7 and end bit,
// one bit per falling sd_clk edge

module sd_cmd_tx (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     sd_fall,
	input  logic                     cmd_start,
	input  sd_proto_pkg::cmd_index_t cmd_index,
	input  sd_proto_pkg::cmd_arg_t   cmd_arg,
	output logic                     cmd_out,
	output logic                     cmd_oe,
	output logic                     cmd_done
);

	typedef enum logic {tx_idle, tx_busy} tx_state_t;

	tx_state_t state;
	logic [39:0] tx_shift;    // crc covered part of the frame
	sd_proto_pkg::crc7_t crc;
	logic [5:0] bit_cnt;      // bits already driven
	logic crc_fb;

	assign crc_fb = crc[6] ^ tx_shift[39];

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= tx_idle;
			bit_cnt <= '0;
			cmd_out <= 1'b1;
			cmd_oe <= 1'b0;
			cmd_done <= 1'b0;
		end
		else
		begin
			cmd_done <= 1'b0;
			case (state)
				tx_idle:
					if (cmd_start)
					begin
						bit_cnt <= '0;
						state <= tx_busy;
					end
				tx_busy:
					if (sd_fall)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 6'(sd_proto_pkg::cmd_frame_bits))
						begin
							cmd_done <= 1'b1; // end bit has had its full period
							cmd_oe <= 1'b0;
							cmd_out <= 1'b1;
							state <= tx_idle;
						end
						else
						begin
							cmd_oe <= 1'b1;
							if (bit_cnt < 6'($bits(tx_shift)))
								cmd_out <= tx_shift[39];
							else if (bit_cnt < 6'(sd_proto_pkg::cmd_frame_bits - 1))
								cmd_out <= crc[6];
							else
								cmd_out <= 1'b1; // end bit
						end
					end
				default:
					state <= tx_idle;
			endcase
		end
	end

	// frame shifter and serial CRC7, polynomial x^7 + x^3 + 1
	always_ff @(posedge sys_clk)
	begin
		if (state == tx_idle && cmd_start)
		begin
			tx_shift <= {1'b0, 1'b1, cmd_index, cmd_arg};
			crc <= '0;
		end
		else if (state == tx_busy && sd_fall)
		begin
			if (bit_cnt < 6'($bits(tx_shift)))
			begin
				tx_shift <= {tx_shift[38:0], 1'b0};
				crc <= {crc[5:3], crc[2] ^ crc_fb, crc[1:0], crc_fb};
			end
			else
			begin
				crc <= {crc[5:0], 1'b0}; // crc leaves msb first
			end
		end
	end

	// a new command only after the previous one has finished
	a_no_overlap: assert property (@(posedge sys_clk) disable iff (rst)
		cmd_start |=> (!cmd_start until_with cmd_done));

endmodule

// ==== logic/sd_resp_rx.sv ====
// SD short response receiver
// waits for the response start bit, then shifts in the 48-bit frame
// on rising sd_clk edges, or reports a timeout

module sd_resp_rx (
	input  logic                      sys_clk,
	input  logic                      rst,
	input  logic                      sd_rise,
	input  logic                      resp_start,
	input  logic                      cmd_in,
	output sd_proto_pkg::resp_frame_t resp_frame,
	output logic                      resp_timeout,
	output logic                      resp_done
);

	typedef enum logic [1:0] {rx_idle, rx_wait, rx_shift} rx_state_t;

	rx_state_t state;
	logic [$clog2(sd_proto_pkg::resp_timeout_ticks)-1:0] tick_cnt;
	logic [5:0] bit_cnt; // frame bits taken so far

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= rx_idle;
			tick_cnt <= '0;
			bit_cnt <= '0;
			resp_timeout <= 1'b0;
			resp_done <= 1'b0;
		end
		else
		begin
			resp_done <= 1'b0;
			if (resp_start)
			begin
				tick_cnt <= '0;
				state <= rx_wait;
			end
			else if (sd_rise)
			begin
				case (state)
					rx_wait:
						if (!cmd_in)
						begin
							bit_cnt <= 6'd1; // start bit already in
							state <= rx_shift;
						end
						else if (tick_cnt == $bits(tick_cnt)'(sd_proto_pkg::resp_timeout_ticks - 1))
						begin
							resp_timeout <= 1'b1;
							resp_done <= 1'b1;
							state <= rx_idle;
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					rx_shift:
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 6'(sd_proto_pkg::cmd_frame_bits - 1))
						begin
							resp_timeout <= 1'b0;
							resp_done <= 1'b1;
							state <= rx_idle;
						end
					end
					default:
						state <= rx_idle;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (sd_rise && !resp_start && (state == rx_shift || (state == rx_wait && !cmd_in)))
			resp_frame <= {resp_frame[46:0], cmd_in};
	end

endmodule

// ==== logic/sd_data_rx.sv ====
// SD 4-bit data block receiver
// waits for the start nibble, packs 512 bytes high nibble first,
// then steps over the CRC16 nibbles and the end nibble

module sd_data_rx (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     sd_rise,
	input  logic                     data_start,
	input  logic [3:0]               dat_in,
	output sd_host_pkg::byte_t       data_byte,
	output sd_host_pkg::byte_index_t byte_index,
	output logic                     byte_valid,
	output logic                     data_timeout,
	output logic                     data_done
);

	typedef enum logic [1:0] {dx_idle, dx_wait, dx_data, dx_tail} dx_state_t;

	dx_state_t state;
	logic [$clog2(sd_host_pkg::data_timeout_ticks)-1:0] tick_cnt;
	sd_host_pkg::byte_index_t byte_cnt; // next byte to complete
	logic low_nib;                      // next nibble closes a byte
	logic [4:0] tail_cnt;

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= dx_idle;
			tick_cnt <= '0;
			byte_cnt <= '0;
			byte_index <= '0;
			low_nib <= 1'b0;
			tail_cnt <= '0;
			byte_valid <= 1'b0;
			data_timeout <= 1'b0;
			data_done <= 1'b0;
		end
		else
		begin
			byte_valid <= 1'b0;
			data_done <= 1'b0;
			if (data_start)
			begin
				tick_cnt <= '0;
				state <= dx_wait;
			end
			else if (sd_rise)
			begin
				case (state)
					dx_wait:
						if (dat_in == 4'h0)
						begin
							byte_cnt <= '0;
							low_nib <= 1'b0;
							state <= dx_data;
						end
						else if (tick_cnt == $bits(tick_cnt)'(sd_host_pkg::data_timeout_ticks - 1))
						begin
							data_timeout <= 1'b1;
							data_done <= 1'b1;
							state <= dx_idle;
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					dx_data:
					begin
						low_nib <= ~low_nib;
						if (low_nib)
						begin
							byte_valid <= 1'b1;
							byte_index <= byte_cnt;
							byte_cnt <= byte_cnt + 1'b1;
							if (byte_cnt == 9'(sd_proto_pkg::block_bytes - 1))
							begin
								tail_cnt <= '0;
								state <= dx_tail;
							end
						end
					end
					dx_tail:
						if (tail_cnt == 5'(sd_proto_pkg::data_crc_bits))
						begin
							data_timeout <= 1'b0; // this rise carried the end nibble
							data_done <= 1'b1;
							state <= dx_idle;
						end
						else
						begin
							tail_cnt <= tail_cnt + 1'b1;
						end
					default:
						state <= dx_idle;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (sd_rise && !data_start && state == dx_data)
			data_byte <= {data_byte[3:0], dat_in};
	end

	a_no_byte_in_wait: assert property (@(posedge sys_clk) disable iff (rst)
		(state == dx_wait) |-> !byte_valid);

endmodule

// ==== logic/sd_read_ctrl.sv ====
// SD block range read sequencer
// issues one CMD17 per block from start_block to end_block, checks the R1
// and the data block, and aborts with read_error on a fault

module sd_read_ctrl (
	input  logic                      sys_clk,
	input  logic                      rst,
	input  logic                      read_req,
	input  sd_host_pkg::block_addr_t  start_block,
	input  sd_host_pkg::block_addr_t  end_block,
	input  logic                      high_capacity,
	output logic                      cmd_start,
	output sd_proto_pkg::cmd_index_t  cmd_index,
	output sd_proto_pkg::cmd_arg_t    cmd_arg,
	input  logic                      cmd_done,
	output logic                      resp_start,
	output logic                      data_start,
	input  sd_proto_pkg::resp_frame_t resp_frame,
	input  logic                      resp_timeout,
	input  logic                      resp_done,
	input  logic                      data_timeout,
	input  logic                      data_done,
	output sd_host_pkg::block_addr_t  block_number,
	output logic                      idle,
	output logic                      read_error
);

	typedef enum logic [2:0] {
		st_idle,
		st_issue,  // cmd_start cycle
		st_cmd,
		st_launch, // arm both receivers
		st_wait,
		st_abort
	} ctrl_state_t;

	ctrl_state_t state;
	sd_host_pkg::block_addr_t cur_block;
	sd_host_pkg::block_addr_t last_block;
	logic hc_mode;
	logic resp_ok;
	logic data_ok;
	logic resp_bad;
	logic block_end;

	assign cmd_start = (state == st_issue);
	assign cmd_index = sd_proto_pkg::cmd_read_single;
	assign cmd_arg = hc_mode ? cur_block : cur_block << sd_proto_pkg::std_addr_shift;
	assign resp_start = (state == st_launch);
	assign data_start = (state == st_launch); // data may start before the R1 ends
	assign idle = (state == st_idle);
	assign read_error = (state == st_abort);

	assign resp_bad = resp_timeout || (resp_frame[45:40] != sd_proto_pkg::cmd_read_single);
	assign block_end = (resp_ok || resp_done) && (data_ok || data_done);

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			cur_block <= '0;
			last_block <= '0;
			hc_mode <= 1'b0;
			resp_ok <= 1'b0;
			data_ok <= 1'b0;
			block_number <= '0;
		end
		else
		begin
			case (state)
				st_idle:
					if (read_req)
					begin
						cur_block <= start_block;
						last_block <= end_block;
						hc_mode <= high_capacity;
						block_number <= '0;
						state <= st_issue;
					end
				st_issue:
				begin
					resp_ok <= 1'b0;
					data_ok <= 1'b0;
					state <= st_cmd;
				end
				st_cmd:
					if (cmd_done)
						state <= st_launch;
				st_launch:
					state <= st_wait;
				st_wait:
					if ((resp_done && resp_bad) || (data_done && data_timeout))
					begin
						state <= st_abort;
					end
					else if (block_end)
					begin
						if (cur_block >= last_block)
						begin
							state <= st_idle; // whole range read
						end
						else
						begin
							cur_block <= cur_block + 1'b1;
							block_number <= block_number + 1'b1;
							state <= st_issue;
						end
					end
					else
					begin
						if (resp_done)
							resp_ok <= 1'b1;
						if (data_done)
							data_ok <= 1'b1;
					end
				st_abort:
					state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

// ==== logic/sd_read_top.sv ====
// SD card read host top level
// clock divider, command path, response and data receivers and the sequencer,
// with the tristate command pin

module sd_read_top (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     read_req,
	input  sd_host_pkg::block_addr_t start_block,
	input  sd_host_pkg::block_addr_t end_block,
	input  logic                     high_capacity,
	output logic                     sd_clk,
	inout  wire                      sd_cmd,
	input  logic [3:0]               sd_dat,
	output sd_host_pkg::byte_t       data_byte,
	output sd_host_pkg::byte_index_t byte_index,
	output logic                     byte_valid,
	output sd_host_pkg::block_addr_t block_number,
	output logic                     idle,
	output logic                     read_error
);

	logic sd_rise;
	logic sd_fall;
	logic cmd_start;
	sd_proto_pkg::cmd_index_t cmd_index;
	sd_proto_pkg::cmd_arg_t cmd_arg;
	logic cmd_out;
	logic cmd_oe;
	logic cmd_done;
	logic cmd_in;
	logic resp_start;
	sd_proto_pkg::resp_frame_t resp_frame;
	logic resp_timeout;
	logic resp_done;
	logic data_start;
	logic data_timeout;
	logic data_done;

	assign sd_cmd = cmd_oe ? cmd_out : 1'bz; // released between commands
	assign cmd_in = sd_cmd;

	sd_clk_div sd_clk_div_i (
		.sys_clk (sys_clk),
		.rst     (rst),
		.sd_clk  (sd_clk),
		.sd_rise (sd_rise),
		.sd_fall (sd_fall)
	);

	sd_cmd_tx sd_cmd_tx_i (
		.sys_clk   (sys_clk),
		.rst       (rst),
		.sd_fall   (sd_fall),
		.cmd_start (cmd_start),
		.cmd_index (cmd_index),
		.cmd_arg   (cmd_arg),
		.cmd_out   (cmd_out),
		.cmd_oe    (cmd_oe),
		.cmd_done  (cmd_done)
	);

	sd_resp_rx sd_resp_rx_i (
		.sys_clk      (sys_clk),
		.rst          (rst),
		.sd_rise      (sd_rise),
		.resp_start   (resp_start),
		.cmd_in       (cmd_in),
		.resp_frame   (resp_frame),
		.resp_timeout (resp_timeout),
		.resp_done    (resp_done)
	);

	sd_data_rx sd_data_rx_i (
		.sys_clk      (sys_clk),
		.rst          (rst),
		.sd_rise      (sd_rise),
		.data_start   (data_start),
		.dat_in       (sd_dat),
		.data_byte    (data_byte),
		.byte_index   (byte_index),
		.byte_valid   (byte_valid),
		.data_timeout (data_timeout),
		.data_done    (data_done)
	);

	sd_read_ctrl sd_read_ctrl_i (
		.sys_clk       (sys_clk),
		.rst           (rst),
		.read_req      (read_req),
		.start_block   (start_block),
		.end_block     (end_block),
		.high_capacity (high_capacity),
		.cmd_start     (cmd_start),
		.cmd_index     (cmd_index),
		.cmd_arg       (cmd_arg),
		.cmd_done      (cmd_done),
		.resp_start    (resp_start),
		.data_start    (data_start),
		.resp_frame    (resp_frame),
		.resp_timeout  (resp_timeout),
		.resp_done     (resp_done),
		.data_timeout  (data_timeout),
		.data_done     (data_done),
		.block_number  (block_number),
		.idle          (idle),
		.read_error    (read_error)
	);

endmodule

// ==== tb/sd_card_model.sv ====
// behavioural SD card for the read path
// decodes commands, checks their CRC7, answers CMD17 with an R1 and sends one block

module sd_card_model (
	input  logic                   sd_clk,
	inout  wire                    sd_cmd,
	output logic [3:0]             sd_dat,
	input  logic                   silent,
	input  logic                   bad_index,
	input  logic                   no_data,
	output int                     cmd_count,
	output int                     crc_errors,
	output sd_proto_pkg::cmd_arg_t last_arg
);

	logic drive_en;
	logic drive_bit;

	assign sd_cmd = drive_en ? drive_bit : 1'bz;

	// serial CRC7, x^7 + x^3 + 1, msb first
	function automatic sd_proto_pkg::crc7_t crc7_of(input logic [39:0] bits);
		sd_proto_pkg::crc7_t c;
		logic fb;
		c = '0;
		for (int i = 39; i >= 0; i--)
		begin
			fb = c[6] ^ bits[i];
			c = {c[5:0], 1'b0};
			if (fb)
				c = c ^ 7'h09;
		end
		return c;
	endfunction

	task automatic get_command(output logic [47:0] frame);
		@(posedge sd_clk);
		while (sd_cmd !== 1'b0)
			@(posedge sd_clk);
		frame[47] = 1'b0; // start bit
		for (int i = 46; i >= 0; i--)
		begin
			@(posedge sd_clk);
			frame[i] = sd_cmd;
		end
	endtask

	task automatic send_response(input sd_proto_pkg::cmd_index_t idx);
		logic [47:0] r;
		r = {1'b0, 1'b0, idx, 32'h0000_0900, 8'h00}; // status says tran, ready for data
		r[7:1] = crc7_of(r[47:8]);
		r[0] = 1'b1;
		@(negedge sd_clk); // host still drives the end bit period here
		@(negedge sd_clk);
		for (int i = 47; i >= 0; i--)
		begin
			#2;
			drive_bit = r[i];
			drive_en = 1'b1;
			@(negedge sd_clk);
		end
		#2;
		drive_en = 1'b0;
		drive_bit = 1'b1;
	endtask

	task automatic send_block(input sd_proto_pkg::cmd_arg_t arg);
		sd_host_pkg::byte_t b;
		@(negedge sd_clk);
		#2;
		sd_dat = 4'h0; // start nibble
		for (int i = 0; i < sd_proto_pkg::block_bytes; i++)
		begin
			b = arg[7:0] + 8'(i);
			@(negedge sd_clk);
			#2;
			sd_dat = b[7:4];
			@(negedge sd_clk);
			#2;
			sd_dat = b[3:0];
		end
		for (int i = 0; i < sd_proto_pkg::data_crc_bits; i++)
		begin
			@(negedge sd_clk);
			#2;
			sd_dat = 4'h0; // crc not checked by the host
		end
		@(negedge sd_clk);
		#2;
		sd_dat = 4'hf; // end nibble, then idle level
	endtask

	initial
	begin
		logic [47:0] frame;
		logic valid;
		drive_en = 1'b0;
		drive_bit = 1'b1;
		sd_dat = 4'hf;
		cmd_count = 0;
		crc_errors = 0;
		last_arg = '0;
		forever
		begin
			get_command(frame);
			valid = frame[46] && frame[0] && (frame[45:40] == sd_proto_pkg::cmd_read_single);
			if (crc7_of(frame[47:8]) != frame[7:1])
			begin
				crc_errors++;
				valid = 1'b0;
			end
			if (valid)
			begin
				cmd_count++;
				last_arg = frame[39:8];
				if (!silent)
				begin
					send_response(bad_index ? 6'd16 : sd_proto_pkg::cmd_read_single);
					if (!no_data && !bad_index)
						send_block(frame[39:8]);
				end
			end
		end
	end

endmodule

// ==== tb/tb_sd_read_top.sv ====
// testbench for the SD read host
// directed tests against the behavioural card, with byte monitor and run limit

module tb_sd_read_top;

	localparam int cycle_limit = 80000; // about 6000 cycles per block, ten blocks, timeouts
	localparam int drive_delay = 2;

	logic sys_clk;
	logic rst;
	logic read_req;
	sd_host_pkg::block_addr_t start_block;
	sd_host_pkg::block_addr_t end_block;
	logic high_capacity;
	logic sd_clk;
	wire sd_cmd;
	logic [3:0] sd_dat;
	sd_host_pkg::byte_t data_byte;
	sd_host_pkg::byte_index_t byte_index;
	logic byte_valid;
	sd_host_pkg::block_addr_t block_number;
	logic idle;
	logic read_error;
	logic silent;
	logic bad_index;
	logic no_data;
	int cmd_count;
	int crc_errors;
	sd_proto_pkg::cmd_arg_t last_arg;

	integer seed;
	int err_count;
	int pass_count;
	int fail_count;
	int cycle_count;
	int cmd_base;        // model command count at test start
	int byte_count;
	int error_pulses;
	int idle_cmd_errors; // command line low while host idle
	int blocks_seen;
	sd_host_pkg::byte_index_t next_index;
	sd_host_pkg::block_addr_t exp_start;
	logic exp_hc;

	pullup (sd_cmd);

	sd_read_top sd_read_top_i (
		.sys_clk       (sys_clk),
		.rst           (rst),
		.read_req      (read_req),
		.start_block   (start_block),
		.end_block     (end_block),
		.high_capacity (high_capacity),
		.sd_clk        (sd_clk),
		.sd_cmd        (sd_cmd),
		.sd_dat        (sd_dat),
		.data_byte     (data_byte),
		.byte_index    (byte_index),
		.byte_valid    (byte_valid),
		.block_number  (block_number),
		.idle          (idle),
		.read_error    (read_error)
	);

	sd_card_model sd_card_model_i (
		.sd_clk     (sd_clk),
		.sd_cmd     (sd_cmd),
		.sd_dat     (sd_dat),
		.silent     (silent),
		.bad_index  (bad_index),
		.no_data    (no_data),
		.cmd_count  (cmd_count),
		.crc_errors (crc_errors),
		.last_arg   (last_arg)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever
			#10 sys_clk = ~sys_clk;
	end

	// argument of the k-th block of a request
	function automatic sd_proto_pkg::cmd_arg_t expected_arg(
		input sd_host_pkg::block_addr_t first, input int k, input logic hc);
		sd_host_pkg::block_addr_t blk;
		blk = first + k;
		return hc ? blk : blk * 512;
	endfunction

	task automatic compare_byte(input sd_host_pkg::byte_t got, input sd_host_pkg::byte_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_index(input sd_host_pkg::byte_index_t got,
		input sd_host_pkg::byte_index_t exp, input string what);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_block(input sd_host_pkg::block_addr_t got,
		input sd_host_pkg::block_addr_t exp, input string what);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_arg(input sd_proto_pkg::cmd_arg_t got, input sd_proto_pkg::cmd_arg_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			err_count++;
		end
	endtask

	// byte stream, error pulse and idle line monitor
	always @(posedge sys_clk)
	begin
		if (!rst && byte_valid)
		begin
			compare_index(byte_index, next_index, "byte index");
			compare_byte(data_byte,
				sd_host_pkg::byte_t'(expected_arg(exp_start, blocks_seen, exp_hc)) + next_index[7:0],
				"data byte");
			compare_block(block_number, sd_host_pkg::block_addr_t'(blocks_seen), "block number");
			if (next_index == 9'd511)
			begin
				compare_arg(last_arg, expected_arg(exp_start, blocks_seen, exp_hc), "CMD17 argument");
				blocks_seen++;
			end
			next_index = next_index + 1'b1; // wraps to 0 after 511
			byte_count++;
		end
		if (!rst && read_error)
			error_pulses++;
		if (!rst && idle && sd_cmd === 1'b0)
			idle_cmd_errors++;
	end

	always @(posedge sys_clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic send_request(input sd_host_pkg::block_addr_t first,
		input sd_host_pkg::block_addr_t last, input logic hc);
		@(posedge sys_clk);
		#drive_delay;
		start_block = first;
		end_block = last;
		high_capacity = hc;
		read_req = 1'b1;
		@(posedge sys_clk);
		#drive_delay;
		read_req = 1'b0;
	endtask

	task automatic wait_idle();
		do
			@(posedge sys_clk);
		while (!idle);
		@(posedge sys_clk); // let the monitor settle
		#drive_delay;
	endtask

	task automatic prepare_test(input sd_host_pkg::block_addr_t first, input logic hc);
		exp_start = first;
		exp_hc = hc;
		byte_count = 0;
		blocks_seen = 0;
		next_index = '0;
		error_pulses = 0;
		cmd_base = cmd_count;
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before)
		begin
			pass_count++;
			$display("%s: passed", name);
		end
		else
		begin
			fail_count++;
			$display("%s: failed", name);
		end
	endtask

	// outputs while rst is still high
	task automatic test_reset_state();
		int errs_before;
		errs_before = err_count;
		compare_count(int'(idle), 1, "idle in reset");
		compare_count(int'(sd_clk), 0, "sd_clk in reset");
		compare_count(int'(read_error), 0, "read_error in reset");
		compare_count(int'(byte_valid), 0, "byte_valid in reset");
		report_test("reset state", errs_before);
	endtask

	task automatic test_single_std();
		int errs_before;
		sd_host_pkg::block_addr_t blk;
		errs_before = err_count;
		blk = sd_host_pkg::block_addr_t'($random(seed)) & 32'h003f_ffff;
		prepare_test(blk, 1'b0);
		send_request(blk, blk, 1'b0);
		wait_idle();
		compare_count(byte_count, 512, "bytes received");
		compare_count(cmd_count - cmd_base, 1, "CMD17 count");
		compare_arg(last_arg, blk * 512, "CMD17 byte address");
		compare_count(error_pulses, 0, "read_error pulses");
		report_test("single block, standard capacity", errs_before);
	endtask

	task automatic test_multi_hc();
		int errs_before;
		sd_host_pkg::block_addr_t blk;
		errs_before = err_count;
		blk = sd_host_pkg::block_addr_t'($random(seed)) & 32'h0fff_ffff;
		prepare_test(blk, 1'b1);
		send_request(blk, blk + 2, 1'b1);
		wait_idle();
		compare_count(byte_count, 1536, "bytes received");
		compare_count(blocks_seen, 3, "blocks received");
		compare_count(cmd_count - cmd_base, 3, "CMD17 count");
		compare_arg(last_arg, blk + 2, "last CMD17 block address");
		compare_count(error_pulses, 0, "read_error pulses");
		report_test("three blocks, high capacity", errs_before);
	endtask

	task automatic test_crc_and_idle();
		int errs_before;
		errs_before = err_count;
		compare_count(crc_errors, 0, "CRC7 mismatches at the card");
		compare_count(idle_cmd_errors, 0, "command cycles while idle");
		report_test("command CRC7 and idle line", errs_before);
	endtask

	task automatic test_resp_timeout();
		int errs_before;
		errs_before = err_count;
		silent = 1'b1;
		prepare_test(32'd5, 1'b1);
		send_request(32'd5, 32'd5, 1'b1);
		wait_idle();
		compare_count(error_pulses, 1, "read_error pulses");
		compare_count(byte_count, 0, "bytes received");
		silent = 1'b0;
		report_test("response timeout", errs_before);
	endtask

	task automatic test_bad_index_no_data();
		int errs_before;
		errs_before = err_count;
		bad_index = 1'b1;
		prepare_test(32'd9, 1'b1);
		send_request(32'd9, 32'd9, 1'b1);
		wait_idle();
		compare_count(error_pulses, 1, "read_error pulses on index 16");
		compare_count(byte_count, 0, "bytes received on index 16");
		bad_index = 1'b0;
		no_data = 1'b1;
		prepare_test(32'd12, 1'b1);
		send_request(32'd12, 32'd12, 1'b1);
		wait_idle();
		compare_count(error_pulses, 1, "read_error pulses without data");
		compare_count(byte_count, 0, "bytes received without data");
		no_data = 1'b0;
		report_test("wrong response index and data timeout", errs_before);
	endtask

	task automatic test_idle_ignore();
		int errs_before;
		errs_before = err_count;
		prepare_test(32'd40, 1'b1);
		send_request(32'd40, 32'd41, 1'b1);
		repeat (50)
			@(posedge sys_clk);
		compare_count(int'(idle), 0, "idle during transfer");
		send_request(32'd700, 32'd710, 1'b1); // must be ignored
		wait_idle();
		compare_count(cmd_count - cmd_base, 2, "CMD17 count");
		compare_count(byte_count, 1024, "bytes received");
		compare_count(error_pulses, 0, "read_error pulses");
		report_test("request while busy", errs_before);
	endtask

	initial
	begin
		seed = 34;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		cycle_count = 0;
		idle_cmd_errors = 0;
		prepare_test('0, 1'b0);
		rst = 1'b1;
		read_req = 1'b0;
		start_block = '0;
		end_block = '0;
		high_capacity = 1'b0;
		silent = 1'b0;
		bad_index = 1'b0;
		no_data = 1'b0;
		repeat (2)
			@(posedge sys_clk);
		#drive_delay;
		test_reset_state();
		rst = 1'b0;
		test_single_std();
		test_multi_hc();
		test_resp_timeout();
		test_bad_index_no_data();
		test_idle_ignore();
		test_crc_and_idle(); // covers every command of the run
		$display("summary: %0d passed, %0d failed", pass_count, fail_count);
		if (err_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== sd_read_top.f ====
logic/sd_proto_pkg.sv
logic/sd_host_pkg.sv
logic/sd_clk_div.sv
logic/sd_cmd_tx.sv
logic/sd_resp_rx.sv
logic/sd_data_rx.sv
logic/sd_read_ctrl.sv
logic/sd_read_top.sv
tb/sd_card_model.sv
tb/tb_sd_read_top.sv

// ==== Bender.yml ====
package:
  name: sd_read_top

sources:
  - logic/sd_proto_pkg.sv
  - logic/sd_host_pkg.sv
  - logic/sd_clk_div.sv
  - logic/sd_cmd_tx.sv
  - logic/sd_resp_rx.sv
  - logic/sd_data_rx.sv
  - logic/sd_read_ctrl.sv
  - logic/sd_read_top.sv
  - target: test
    files:
      - tb/sd_card_model.sv
      - tb/tb_sd_read_top.sv
